// File: hw/correlator_pkg.sv
package correlator_pkg;

   // ------------------------------------------------------------------
   // Sizes
   // ------------------------------------------------------------------
   localparam int ACCUM_W   = 12;           // Accumulator and bus data width
   localparam int N_ANT     = 12;           // Antennas per sample
   localparam int N_PAIRS   = 12;           // Pairs walked per sweep
   localparam int N_CORR    = 4;            // Correlators in the block
   localparam int VIS_WORDS = 2 * N_PAIRS;  // Cos and sin word per pair
   localparam int PAIR_W    = 4;            // Pair counter and pair address field
   localparam int ANT_W     = 4;            // Antenna index width

   // Antenna pairs per correlator with one {ant_a, ant_b} entry per step
   localparam logic [2*ANT_W-1:0] PAIR_TABLE [N_CORR][N_PAIRS] = '{
      '{8'h60, 8'h70, 8'h80, 8'h90, 8'ha0, 8'hb0,
        8'h61, 8'h71, 8'h81, 8'h91, 8'ha1, 8'hb1},
      '{8'h62, 8'h72, 8'h82, 8'h92, 8'ha2, 8'hb2,
        8'h63, 8'h73, 8'h83, 8'h93, 8'ha3, 8'hb3},
      '{8'h64, 8'h74, 8'h84, 8'h94, 8'ha4, 8'hb4,
        8'h65, 8'h75, 8'h85, 8'h95, 8'ha5, 8'hb5},
      '{8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h21,   // Short baselines
        8'h31, 8'h41, 8'h51, 8'h32, 8'h42, 8'h43}
   };

   // ------------------------------------------------------------------
   // Types
   // ------------------------------------------------------------------
   typedef struct packed {
      logic [N_ANT-1:0] re;                 // Real sign bits, 1 means +1
      logic [N_ANT-1:0] im;                 // Imaginary sign bits
   } ant_sample_t;

   typedef struct packed {
      logic               cyc;
      logic               stb;
      logic               we;               // Writes get an ack only
      logic [6:0]         adr;              // {corr, pair, kind}
      logic [ACCUM_W-1:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic               ack;
      logic [ACCUM_W-1:0] dat;
   } bus_rsp_t;

   // Low address bit picks the visibility
   typedef enum logic {VIS_COS = 1'b0, VIS_SIN = 1'b1} vis_kind_e;

   typedef enum logic {CORR_IDLE = 1'b0, CORR_RUN = 1'b1} corr_state_e;

endpackage

// File: hw/visibility_bank.sv
`timescale 1ns/100ps

module visibility_bank (
   input  logic                               clk_x,
   input  logic                               reset_i,
   input  logic                               bank_i,     // Active bank
   input  logic                               switch_i,   // Pulse after a bank flip
   // Accumulate port on the active bank
   input  logic                               wr_en_i,
   input  logic [correlator_pkg::PAIR_W-1:0]  wr_pair_i,
   input  logic [correlator_pkg::ACCUM_W-1:0] cos_wr_i,
   input  logic [correlator_pkg::ACCUM_W-1:0] sin_wr_i,
   output logic [correlator_pkg::ACCUM_W-1:0] cos_rd_o,
   output logic [correlator_pkg::ACCUM_W-1:0] sin_rd_o,
   // Bus port on the inactive bank
   input  logic                               stb_i,
   input  logic [4:0]                         adr_i,
   output logic                               ack_o,
   output logic [correlator_pkg::ACCUM_W-1:0] dat_o
);

   logic [correlator_pkg::ACCUM_W-1:0] cos_mem [2][correlator_pkg::N_PAIRS];
   logic [correlator_pkg::ACCUM_W-1:0] sin_mem [2][correlator_pkg::N_PAIRS];
   logic [1:0][correlator_pkg::N_PAIRS-1:0] stale_q;   // Entry reads as zero

   logic                               rd_bank;
   logic [correlator_pkg::PAIR_W-1:0]  rd_pair;
   correlator_pkg::vis_kind_e          rd_kind;
   logic                               rd_hit;
   logic                               rd_take;
   logic [correlator_pkg::ACCUM_W-1:0] rd_word;
   logic                               ack_q;
   logic [correlator_pkg::ACCUM_W-1:0] dat_q;

   // ------------------------------------------------------------------
   // Accumulate side
   // ------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (wr_en_i) begin
         cos_mem[bank_i][wr_pair_i] <= cos_wr_i;
         sin_mem[bank_i][wr_pair_i] <= sin_wr_i;
      end
   end

   always_ff @(posedge clk_x) begin
      if (reset_i) begin
         stale_q <= '1;                                     // Both banks empty
      end else begin
         if (switch_i) stale_q[bank_i] <= '1;               // Clear-on-first-use
         if (wr_en_i)  stale_q[bank_i][wr_pair_i] <= 1'b0;  // Write wins
      end
   end

   // Stale entries add to zero
   assign cos_rd_o = stale_q[bank_i][wr_pair_i] ? '0 : cos_mem[bank_i][wr_pair_i];
   assign sin_rd_o = stale_q[bank_i][wr_pair_i] ? '0 : sin_mem[bank_i][wr_pair_i];

   // ------------------------------------------------------------------
   // Bus side
   // ------------------------------------------------------------------
   assign rd_bank = ~bank_i;                       // Frozen bank only
   assign rd_pair = adr_i[4:1];
   assign rd_kind = correlator_pkg::vis_kind_e'(adr_i[0]);
   assign rd_hit  = (adr_i < correlator_pkg::VIS_WORDS) && !stale_q[rd_bank][rd_pair];
   assign rd_take = stb_i & ~ack_q;                // First cycle of a request

   always_comb begin
      rd_word = '0;                                // Pairs 12..15 and stale
      if (rd_hit) begin
         if (rd_kind == correlator_pkg::VIS_COS) rd_word = cos_mem[rd_bank][rd_pair];
         else                                    rd_word = sin_mem[rd_bank][rd_pair];
      end
   end

   always_ff @(posedge clk_x) begin
      if (reset_i) ack_q <= 1'b0;
      else         ack_q <= rd_take;               // Single-cycle pulse
   end

   always_ff @(posedge clk_x) begin
      if (rd_take) dat_q <= rd_word;
   end

   assign ack_o = ack_q;
   assign dat_o = dat_q;

endmodule

// File: hw/correlator.sv
`timescale 1ns/100ps

module correlator #(
   parameter int CORR_IDX = 0                      // Row of the pair table
) (
   input  logic                               clk_x,
   input  logic                               reset_i,
   // Bus slice for this correlator
   input  logic                               stb_i,
   input  logic [4:0]                         adr_i,
   output logic                               ack_o,
   output logic [correlator_pkg::ACCUM_W-1:0] dat_o,
   // Antenna samples
   input  logic                               en_i,
   input  correlator_pkg::ant_sample_t        sample_i,
   // Bank control from the config block
   input  logic                               bank_i,
   input  logic                               switch_i,
   output logic                               ovf_cos_o,
   output logic                               ovf_sin_o
);

   localparam int MSB = correlator_pkg::ACCUM_W - 1;

   correlator_pkg::corr_state_e               state_q;
   logic [correlator_pkg::PAIR_W-1:0]         pair_q;
   correlator_pkg::ant_sample_t               sample_q;
   logic [2*correlator_pkg::ANT_W-1:0]        pair_ent;
   logic [correlator_pkg::ANT_W-1:0]          ant_a, ant_b;
   logic                                      prod_vld_q;
   logic signed [2:0]                         prod_cos_q, prod_sin_q;
   logic [correlator_pkg::PAIR_W-1:0]         prod_pair_q;
   logic signed [MSB:0]                       cos_rd, sin_rd;
   logic signed [MSB:0]                       cos_inc, sin_inc;
   logic signed [MSB:0]                       cos_sum, sin_sum;

   // Sum of two sign products, each given as "is +1"
   function automatic logic signed [2:0] term_sum(input logic pos_u, input logic pos_v);
      if (pos_u && pos_v)        return 3'sd2;
      else if (!pos_u && !pos_v) return -3'sd2;
      else                       return 3'sd0;
   endfunction

   // Signed wrap when both inputs share a sign and the sum does not
   function automatic logic wraps(input logic signed [MSB:0] old_v,
                                  input logic signed [MSB:0] inc_v,
                                  input logic signed [MSB:0] sum_v);
      return (old_v[MSB] == inc_v[MSB]) && (sum_v[MSB] != old_v[MSB]);
   endfunction

   // ------------------------------------------------------------------
   // Pair sequencer
   // ------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (reset_i) begin
         state_q <= correlator_pkg::CORR_IDLE;
         pair_q  <= '0;
      end else begin
         case (state_q)
            correlator_pkg::CORR_IDLE: begin
               if (en_i) state_q <= correlator_pkg::CORR_RUN;   // Sweep start
               pair_q <= '0;
            end
            correlator_pkg::CORR_RUN: begin
               if (int'(pair_q) == correlator_pkg::N_PAIRS - 1) begin
                  state_q <= correlator_pkg::CORR_IDLE;
                  pair_q  <= '0;
               end else begin
                  pair_q  <= pair_q + 1'b1;
               end
            end
            default: state_q <= correlator_pkg::CORR_IDLE;
         endcase
      end
   end

   // Sample held for the whole sweep, en_i mid-sweep dropped
   always_ff @(posedge clk_x) begin
      if (en_i && state_q == correlator_pkg::CORR_IDLE) sample_q <= sample_i;
   end

   assign pair_ent = correlator_pkg::PAIR_TABLE[CORR_IDX][pair_q];
   assign ant_a    = pair_ent[2*correlator_pkg::ANT_W-1:correlator_pkg::ANT_W];
   assign ant_b    = pair_ent[correlator_pkg::ANT_W-1:0];

   // ------------------------------------------------------------------
   // Product stage
   // ------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (reset_i) prod_vld_q <= 1'b0;
      else         prod_vld_q <= (state_q == correlator_pkg::CORR_RUN);
   end

   always_ff @(posedge clk_x) begin
      // re_a*re_b + im_a*im_b
      prod_cos_q  <= term_sum(sample_q.re[ant_a] ~^ sample_q.re[ant_b],
                              sample_q.im[ant_a] ~^ sample_q.im[ant_b]);
      // im_a*re_b - re_a*im_b, second term negated by XOR
      prod_sin_q  <= term_sum(sample_q.im[ant_a] ~^ sample_q.re[ant_b],
                              sample_q.re[ant_a] ^  sample_q.im[ant_b]);
      prod_pair_q <= pair_q;
   end

   // ------------------------------------------------------------------
   // Accumulate stage
   // ------------------------------------------------------------------
   assign cos_inc = prod_cos_q;                    // Sign extended
   assign sin_inc = prod_sin_q;
   assign cos_sum = cos_rd + cos_inc;              // Wraps at ACCUM_W
   assign sin_sum = sin_rd + sin_inc;

   assign ovf_cos_o = prod_vld_q & wraps(cos_rd, cos_inc, cos_sum);
   assign ovf_sin_o = prod_vld_q & wraps(sin_rd, sin_inc, sin_sum);

   visibility_bank u_bank (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .bank_i    (bank_i),
      .switch_i  (switch_i),
      .wr_en_i   (prod_vld_q),
      .wr_pair_i (prod_pair_q),
      .cos_wr_i  (cos_sum),
      .sin_wr_i  (sin_sum),
      .cos_rd_o  (cos_rd),
      .sin_rd_o  (sin_rd),
      .stb_i     (stb_i),
      .adr_i     (adr_i),
      .ack_o     (ack_o),
      .dat_o     (dat_o)
   );

endmodule

// File: hw/correlator_ctrl.sv
`timescale 1ns/100ps

module correlator_ctrl (
   input  logic                              clk_x,
   input  logic                              reset_i,
   input  logic                              sw_i,        // Bank swap request
   input  logic [correlator_pkg::N_CORR-1:0] ovf_cos_i,   // Per-correlator pulses
   input  logic [correlator_pkg::N_CORR-1:0] ovf_sin_i,
   output logic                              bank_o,      // Active bank
   output logic                              switch_o,    // One cycle after sw_i
   output logic                              overflow_cos_o,
   output logic                              overflow_sin_o
);

   logic bank_q;
   logic switch_q;
   logic ovf_cos_q;
   logic ovf_sin_q;

   // ------------------------------------------------------------------
   // Bank select and switch pulse
   // ------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (reset_i) begin
         bank_q   <= 1'b0;                     // Bank 0 accumulates first
         switch_q <= 1'b0;
      end else begin
         switch_q <= sw_i;
         if (sw_i) bank_q <= ~bank_q;          // Bus sees new bank next cycle
      end
   end

   // ------------------------------------------------------------------
   // Sticky overflow flags
   // ------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (reset_i) begin
         ovf_cos_q <= 1'b0;
         ovf_sin_q <= 1'b0;
      end else if (sw_i) begin
         // Fresh bank starts clean
         ovf_cos_q <= 1'b0;
         ovf_sin_q <= 1'b0;
      end else begin
         if (|ovf_cos_i) ovf_cos_q <= 1'b1;    // Any correlator
         if (|ovf_sin_i) ovf_sin_q <= 1'b1;
      end
   end

   assign bank_o         = bank_q;
   assign switch_o       = switch_q;
   assign overflow_cos_o = ovf_cos_q;
   assign overflow_sin_o = ovf_sin_q;

endmodule

// File: hw/correlator_block.sv
`timescale 1ns/100ps

module correlator_block (
   input  logic                              clk_x,
   input  logic                              reset_i,
   input  correlator_pkg::bus_req_t          bus_req_i,
   output correlator_pkg::bus_rsp_t          bus_rsp_o,
   input  logic                              en_i,        // Sample valid
   input  correlator_pkg::ant_sample_t       sample_i,
   input  logic                              bank_i,
   input  logic                              switch_i,
   output logic [correlator_pkg::N_CORR-1:0] ovf_cos_o,
   output logic [correlator_pkg::N_CORR-1:0] ovf_sin_o
);

   logic [1:0]                         sel;           // adr[6:5]
   logic                               req;
   logic [correlator_pkg::N_CORR-1:0]  stb_w;
   logic [correlator_pkg::N_CORR-1:0]  ack_w;
   logic [correlator_pkg::ACCUM_W-1:0] dat_w [correlator_pkg::N_CORR];

   // ------------------------------------------------------------------
   // Address decode and response mux
   // ------------------------------------------------------------------
   assign sel = bus_req_i.adr[6:5];
   assign req = bus_req_i.cyc & bus_req_i.stb;

   always_comb begin
      stb_w      = '0;
      stb_w[sel] = req;                       // One-hot strobe
   end

   always_comb begin
      bus_rsp_o.ack = req & ack_w[sel];       // Held adr keeps sel stable
      bus_rsp_o.dat = bus_req_i.we ? '0 : dat_w[sel];   // No data on writes
   end

   // ------------------------------------------------------------------
   // Correlators
   // ------------------------------------------------------------------
   correlator #(.CORR_IDX(0)) u_corr0 (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .stb_i     (stb_w[0]),
      .adr_i     (bus_req_i.adr[4:0]),
      .ack_o     (ack_w[0]),
      .dat_o     (dat_w[0]),
      .en_i      (en_i),
      .sample_i  (sample_i),
      .bank_i    (bank_i),
      .switch_i  (switch_i),
      .ovf_cos_o (ovf_cos_o[0]),
      .ovf_sin_o (ovf_sin_o[0])
   );

   correlator #(.CORR_IDX(1)) u_corr1 (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .stb_i     (stb_w[1]),
      .adr_i     (bus_req_i.adr[4:0]),
      .ack_o     (ack_w[1]),
      .dat_o     (dat_w[1]),
      .en_i      (en_i),
      .sample_i  (sample_i),
      .bank_i    (bank_i),
      .switch_i  (switch_i),
      .ovf_cos_o (ovf_cos_o[1]),
      .ovf_sin_o (ovf_sin_o[1])
   );

   correlator #(.CORR_IDX(2)) u_corr2 (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .stb_i     (stb_w[2]),
      .adr_i     (bus_req_i.adr[4:0]),
      .ack_o     (ack_w[2]),
      .dat_o     (dat_w[2]),
      .en_i      (en_i),
      .sample_i  (sample_i),
      .bank_i    (bank_i),
      .switch_i  (switch_i),
      .ovf_cos_o (ovf_cos_o[2]),
      .ovf_sin_o (ovf_sin_o[2])
   );

   correlator #(.CORR_IDX(3)) u_corr3 (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .stb_i     (stb_w[3]),
      .adr_i     (bus_req_i.adr[4:0]),
      .ack_o     (ack_w[3]),
      .dat_o     (dat_w[3]),
      .en_i      (en_i),
      .sample_i  (sample_i),
      .bank_i    (bank_i),
      .switch_i  (switch_i),
      .ovf_cos_o (ovf_cos_o[3]),
      .ovf_sin_o (ovf_sin_o[3])
   );

endmodule

// File: hw/correlator_top.sv
`timescale 1ns/100ps

module correlator_top (
   input  logic                        clk_x,
   input  logic                        reset_i,
   // Visibility read bus
   input  correlator_pkg::bus_req_t    bus_req_i,
   output correlator_pkg::bus_rsp_t    bus_rsp_o,
   // Sample stream and bank swap
   input  logic                        sw_i,
   input  logic                        en_i,
   input  correlator_pkg::ant_sample_t sample_i,
   // Sticky status
   output logic                        overflow_cos_o,
   output logic                        overflow_sin_o
);

   logic                              bank;       // Active bank
   logic                              switch_p;   // Registered swap pulse
   logic [correlator_pkg::N_CORR-1:0] ovf_cos;
   logic [correlator_pkg::N_CORR-1:0] ovf_sin;

   // ------------------------------------------------------------------
   // Config block
   // ------------------------------------------------------------------
   correlator_ctrl u_ctrl (
      .clk_x          (clk_x),
      .reset_i        (reset_i),
      .sw_i           (sw_i),
      .ovf_cos_i      (ovf_cos),
      .ovf_sin_i      (ovf_sin),
      .bank_o         (bank),
      .switch_o       (switch_p),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   // ------------------------------------------------------------------
   // Correlator array
   // ------------------------------------------------------------------
   correlator_block u_block (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .bus_req_i (bus_req_i),
      .bus_rsp_o (bus_rsp_o),
      .en_i      (en_i),
      .sample_i  (sample_i),
      .bank_i    (bank),
      .switch_i  (switch_p),
      .ovf_cos_o (ovf_cos),
      .ovf_sin_o (ovf_sin)
   );

endmodule

// File: test/tb_correlator_top.sv
`timescale 1ns/100ps

module tb_correlator_top;

   localparam int SPACING  = 16;                  // Cycles from one en_i to the next
   localparam int N_RAND   = 40;
   localparam int N_LIVE   = 20;                  // Samples per run in the frozen bank test
   localparam int N_OVF    = 1100;                // 1024 steps of +2 pass +2047
   localparam int READ_ALL = 128 * 4;
   localparam int TEST_CYCLES = 10 * READ_ALL + 64
                              + (N_RAND + 2 * N_LIVE + 2 * N_OVF + 1) * SPACING;
   localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;
   localparam int MAX_V = 2 ** (correlator_pkg::ACCUM_W - 1) - 1;

   logic                        clk_x = 1'b0;
   logic                        reset_i;
   logic                        sw_i;
   logic                        en_i;
   correlator_pkg::bus_req_t    bus_req;
   correlator_pkg::bus_rsp_t    bus_rsp;
   correlator_pkg::ant_sample_t sample;
   logic                        ovf_cos;
   logic                        ovf_sin;

   // Reference state, [corr][bank][pair][kind]
   int   model [correlator_pkg::N_CORR][2][correlator_pkg::N_PAIRS][2];
   logic model_bank;                              // Active bank
   logic model_ovf_cos;
   logic model_ovf_sin;

   integer                      seed = 32'hfeaf;
   logic [31:0]                 rnd;
   correlator_pkg::ant_sample_t stim;
   int                          errors = 0;
   int                          err_mark;
   int                          tests_ok = 0;
   int                          tests_bad = 0;
   int                          cycles = 0;

   correlator_top u_dut (
      .clk_x          (clk_x),
      .reset_i        (reset_i),
      .bus_req_i      (bus_req),
      .bus_rsp_o      (bus_rsp),
      .sw_i           (sw_i),
      .en_i           (en_i),
      .sample_i       (sample),
      .overflow_cos_o (ovf_cos),
      .overflow_sin_o (ovf_sin)
   );

   always #5 clk_x = ~clk_x;

   // Run limit
   always @(posedge clk_x) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------
   function automatic int sgn(input logic b);
      return b ? 1 : -1;                          // Bit 1 is +1
   endfunction

   function automatic int wrap(input int v);
      if (v > MAX_V)      return v - 2 * (MAX_V + 1);
      if (v < -MAX_V - 1) return v + 2 * (MAX_V + 1);
      return v;
   endfunction

   task automatic apply_sample(input correlator_pkg::ant_sample_t s);
      int a, b, cos_t, sin_t, v;
      logic [7:0] ent;
      for (int c = 0; c < correlator_pkg::N_CORR; c++) begin
         for (int k = 0; k < correlator_pkg::N_PAIRS; k++) begin
            ent   = correlator_pkg::PAIR_TABLE[c][k];
            a     = ent[7:4];
            b     = ent[3:0];
            cos_t = sgn(s.re[a]) * sgn(s.re[b]) + sgn(s.im[a]) * sgn(s.im[b]);
            sin_t = sgn(s.im[a]) * sgn(s.re[b]) - sgn(s.re[a]) * sgn(s.im[b]);
            v = model[c][model_bank][k][0] + cos_t;
            if (wrap(v) != v) model_ovf_cos = 1'b1;   // Signed wrap
            model[c][model_bank][k][0] = wrap(v);
            v = model[c][model_bank][k][1] + sin_t;
            if (wrap(v) != v) model_ovf_sin = 1'b1;
            model[c][model_bank][k][1] = wrap(v);
         end
      end
   endtask

   // Bus view of the inactive bank
   function automatic logic [correlator_pkg::ACCUM_W-1:0] expected(input logic [6:0] adr);
      int v;
      if (adr[4:1] >= correlator_pkg::N_PAIRS) return '0;   // Unused pair codes
      v = model[adr[6:5]][~model_bank][adr[4:1]][adr[0]];
      return v[correlator_pkg::ACCUM_W-1:0];
   endfunction

   // ------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------
   task automatic send_sample(input correlator_pkg::ant_sample_t s, input logic stray);
      @(negedge clk_x);
      en_i   = 1'b1;
      sample = s;
      @(negedge clk_x);
      en_i = 1'b0;
      apply_sample(s);
      repeat (5) @(negedge clk_x);
      en_i   = stray;                             // Lands mid-sweep
      sample = ~s;
      @(negedge clk_x);
      en_i = 1'b0;
      repeat (SPACING - 8) @(negedge clk_x);      // Sweep done, idle again
   endtask

   task automatic send_random(input int n);
      repeat (n) begin
         rnd = $random(seed);
         send_sample(rnd[23:0], 1'b0);
      end
   endtask

   task automatic bank_switch();
      @(negedge clk_x);
      sw_i = 1'b1;
      @(negedge clk_x);
      sw_i          = 1'b0;
      model_bank    = ~model_bank;
      model_ovf_cos = 1'b0;
      model_ovf_sin = 1'b0;
      // Fresh active bank starts from zero
      for (int c = 0; c < correlator_pkg::N_CORR; c++) begin
         for (int k = 0; k < correlator_pkg::N_PAIRS; k++) begin
            model[c][model_bank][k][0] = 0;
            model[c][model_bank][k][1] = 0;
         end
      end
   endtask

   // ------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------
   task automatic check_flags(input string name);
      if (ovf_cos !== model_ovf_cos) begin
         $display("CHECK FAILED %s overflow_cos expected %0b actual %0b",
                  name, model_ovf_cos, ovf_cos);
         errors++;
      end
      if (ovf_sin !== model_ovf_sin) begin
         $display("CHECK FAILED %s overflow_sin expected %0b actual %0b",
                  name, model_ovf_sin, ovf_sin);
         errors++;
      end
   endtask

   // One bus request, held until ack or 4 cycles
   task automatic bus_cycle(input logic we, input logic [6:0] adr, input string name);
      int waited;
      logic [correlator_pkg::ACCUM_W-1:0] exp_v;
      @(negedge clk_x);
      bus_req.cyc = 1'b1;
      bus_req.stb = 1'b1;
      bus_req.we  = we;
      bus_req.adr = adr;
      bus_req.dat = '1;                           // Write data that must not land
      @(negedge clk_x);
      waited = 1;
      while (!bus_rsp.ack && waited < 4) begin
         @(negedge clk_x);
         waited++;
      end
      exp_v = expected(adr);
      if (!bus_rsp.ack) begin
         $display("%s: no ack from address %02h within 4 cycles", name, adr);
         errors++;
      end else if (waited != 1) begin
         $display("%s: ack from address %02h came %0d cycles late", name, adr, waited - 1);
         errors++;
      end else if (!we && bus_rsp.dat !== exp_v) begin
         $display("CHECK FAILED %s adr %02h expected %03h actual %03h",
                  name, adr, exp_v, bus_rsp.dat);
         errors++;
      end
      bus_req.cyc = 1'b0;                         // Idle cycle follows
      bus_req.stb = 1'b0;
      bus_req.we  = 1'b0;
   endtask

   task automatic read_all(input string name);
      for (int a = 0; a < 128; a++)
         bus_cycle(1'b0, a[6:0], name);
   endtask

   task automatic end_test(input string name);
      if (errors == err_mark) begin
         tests_ok++;
         $display("test %-14s passed", name);
      end else begin
         tests_bad++;
         $display("test %-14s failed with %0d errors", name, errors - err_mark);
      end
   endtask

   // ------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------
   initial begin
      reset_i       = 1'b1;
      sw_i          = 1'b0;
      en_i          = 1'b0;
      sample        = '0;
      bus_req       = '0;
      model_bank    = 1'b0;
      model_ovf_cos = 1'b0;
      model_ovf_sin = 1'b0;
      repeat (2) @(negedge clk_x);
      reset_i = 1'b0;

      err_mark = errors;                          // Stale banks read zero
      read_all("reset_zero");
      check_flags("reset_zero");
      end_test("reset_zero");

      err_mark = errors;
      send_random(N_RAND);
      bank_switch();
      read_all("random_sweep");
      end_test("random_sweep");

      err_mark = errors;
      fork
         send_random(N_LIVE);                     // Active bank busy
         read_all("frozen_bank");                 // Inactive bank must hold still
      join
      bank_switch();
      read_all("frozen_bank");
      send_random(N_LIVE);                        // Reuses the bank of random_sweep
      bank_switch();
      read_all("frozen_bank");
      end_test("frozen_bank");

      err_mark = errors;
      repeat (N_OVF) begin
         rnd  = $random(seed);
         stim = {(2 * correlator_pkg::N_ANT){rnd[0]}};   // Every product +1
         send_sample(stim, 1'b0);
         check_flags("overflow_cos");
      end
      if (!ovf_cos) begin
         $display("overflow_cos: flag never rose after %0d equal samples", N_OVF);
         errors++;
      end
      bank_switch();
      check_flags("overflow_cos");
      read_all("overflow_cos");
      stim.re = '1;
      stim.im = 12'hfc0;                          // Antennas 6..11 lead by 90 degrees
      repeat (N_OVF) begin
         send_sample(stim, 1'b0);
         check_flags("overflow_sin");
      end
      if (!ovf_sin) begin
         $display("overflow_sin: flag never rose after %0d phase samples", N_OVF);
         errors++;
      end
      bank_switch();
      check_flags("overflow_sin");
      read_all("overflow_sin");
      end_test("overflow");

      err_mark = errors;
      bus_cycle(1'b1, 7'h07, "write_stray");      // Corr 0, pair 3, sine
      bus_cycle(1'b0, 7'h07, "write_stray");
      rnd = $random(seed);
      send_sample(rnd[23:0], 1'b1);
      bank_switch();
      read_all("write_stray");
      end_test("write_stray");

      $display("tests passed %0d failed %0d", tests_ok, tests_bad);
      if (tests_bad == 0 && errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: src.f
hw/correlator_pkg.sv
hw/visibility_bank.sv
hw/correlator.sv
hw/correlator_ctrl.sv
hw/correlator_block.sv
hw/correlator_top.sv
test/tb_correlator_top.sv

// File: Bender.yml
package:
  name: correlator

sources:
  - hw/correlator_pkg.sv
  - hw/visibility_bank.sv
  - hw/correlator.sv
  - hw/correlator_ctrl.sv
  - hw/correlator_block.sv
  - hw/correlator_top.sv
  - target: test
    files:
      - test/tb_correlator_top.sv
